// ==== exu_defines.svh ====
// --------------------------------------------------------------------
// Widths and fixed vectors of the RV32I execute stage. The trap
// vector is fixed because this stage has no CSR unit.
// --------------------------------------------------------------------

`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

`define EXU_XLEN        32                  // Data and address width
`define EXU_REG_AW      5                   // Register file address width

`define EXU_RST_VECTOR  32'h0000_0200       // PC after reset exit
`define EXU_TRAP_VECTOR 32'h0000_0100       // PC on any trap

`define EXU_JUMP_MASK   32'hFFFF_FFFE       // Clears bit 0 of a target

`endif

// ==== exu_isa_pkg.sv ====
// --------------------------------------------------------------------
// Instruction-set encodings seen by the execute stage. Exception
// codes follow the RISC-V mcause numbering.
// --------------------------------------------------------------------

package exu_isa_pkg;

    typedef enum logic [4:0] {
        IALU_CMD_NONE,
        IALU_CMD_ADD,
        IALU_CMD_SUB,
        IALU_CMD_AND,
        IALU_CMD_OR,
        IALU_CMD_XOR,
        IALU_CMD_SLL,
        IALU_CMD_SRL,
        IALU_CMD_SRA,
        IALU_CMD_SLT,
        IALU_CMD_SLTU,
        IALU_CMD_EQ,                        // Branch compares from here on
        IALU_CMD_NE,
        IALU_CMD_LT,
        IALU_CMD_GE,
        IALU_CMD_LTU,
        IALU_CMD_GEU
    } ialu_cmd_e;

    typedef enum logic {
        IALU_OP_REG_REG,                    // op2 from rs2
        IALU_OP_REG_IMM                     // op2 from imm
    } ialu_op_e;

    typedef enum logic {
        SUM2_OP_PC_IMM,                     // Branch, JAL, AUIPC
        SUM2_OP_REG_IMM                     // JALR
    } sum2_op_e;

    typedef enum logic [2:0] {
        RD_WB_NONE,
        RD_WB_IALU,
        RD_WB_SUM2,
        RD_WB_IMM,
        RD_WB_INC_PC
    } rd_wb_sel_e;

    typedef enum logic [3:0] {
        EXC_CODE_INSTR_MISALIGN = 4'd0,
        EXC_CODE_ILLEGAL_INSTR  = 4'd2,
        EXC_CODE_BREAKPOINT     = 4'd3,
        EXC_CODE_ECALL_M        = 4'd11
    } exc_code_e;

endpackage

// ==== exu_pipe_pkg.sv ====
// --------------------------------------------------------------------
// Pipeline types. The command struct is what the decoder hands over,
// one per accepted instruction.
// --------------------------------------------------------------------

`include "exu_defines.svh"

package exu_pipe_pkg;

    typedef struct packed {
        exu_isa_pkg::ialu_op_e      ialu_op;
        exu_isa_pkg::ialu_cmd_e     ialu_cmd;
        exu_isa_pkg::sum2_op_e      sum2_op;
        exu_isa_pkg::rd_wb_sel_e    rd_wb_sel;
        logic                       jump_req;       // JAL or JALR
        logic                       branch_req;     // Conditional branch
        logic                       exc_req;        // Decoder found an exception
        exu_isa_pkg::exc_code_e     exc_code;
        logic [`EXU_REG_AW-1:0]     rs1_addr;
        logic [`EXU_REG_AW-1:0]     rs2_addr;
        logic [`EXU_REG_AW-1:0]     rd_addr;
        logic [`EXU_XLEN-1:0]       imm;
    } exu_cmd_s;

    // Reset-exit sequencer
    typedef enum logic [1:0] {
        INIT_WAIT1,
        INIT_WAIT2,
        INIT_LOAD,
        INIT_DONE
    } pc_init_e;

endpackage

// ==== exu_stage_if.sv ====
// --------------------------------------------------------------------
// Results of the execute stage for the commit stage. All strobes are
// single-cycle levels with no handshake.
// --------------------------------------------------------------------

`include "exu_defines.svh"

interface exu_stage_if;
    import exu_isa_pkg::*;

    logic                   instret;        // Queued instruction completes
    logic                   jb_taken;       // Jump or taken branch
    logic [`EXU_XLEN-1:0]   jb_target;      // Masked sum2 result
    logic                   exc;            // Trap this cycle
    exc_code_e              exc_code;
    logic [`EXU_XLEN-1:0]   trap_val;

    modport execute (
        output instret,
        output jb_taken,
        output jb_target,
        output exc,
        output exc_code,
        output trap_val
    );

    modport commit (
        input  instret,
        input  jb_taken,
        input  jb_target,
        input  exc,
        input  exc_code,
        input  trap_val
    );

endinterface

// ==== exu_queue.sv ====
// --------------------------------------------------------------------
// One-entry instruction queue. Every request is taken; a request that
// arrives while a new PC is being requested is dropped.
// --------------------------------------------------------------------

module exu_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_req,
    input  exu_pipe_pkg::exu_cmd_s  cmd,
    input  logic                    new_pc_req,
    output logic                    q_vd,
    output exu_pipe_pkg::exu_cmd_s  q_cmd
);

    logic accept;

    assign accept = cmd_req & ~new_pc_req;      // Flush on redirect

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_vd <= 1'b0;
        end else begin
            q_vd <= accept;
        end
    end

    // Payload held while idle
    always_ff @(posedge clk) begin
        if (accept) begin
            q_cmd <= cmd;
        end
    end

    // --------------------------------------------------------------------
    // Checks
    // --------------------------------------------------------------------

    a_cmd_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd_req |-> !$isunknown(cmd)
    ) else $error("exu_queue: unknown bits in a requested command");

endmodule

// ==== exu_ialu.sv ====
// --------------------------------------------------------------------
// Integer ALU with branch compare, plus an independent adder for
// jump, branch and AUIPC targets. Purely combinational.
// --------------------------------------------------------------------

`include "exu_defines.svh"

module exu_ialu (
    input  exu_isa_pkg::ialu_cmd_e  ialu_cmd,
    input  logic [`EXU_XLEN-1:0]    op1,
    input  logic [`EXU_XLEN-1:0]    op2,
    input  logic [`EXU_XLEN-1:0]    sum2_op1,
    input  logic [`EXU_XLEN-1:0]    sum2_op2,
    output logic [`EXU_XLEN-1:0]    res,
    output logic [`EXU_XLEN-1:0]    sum2_res,
    output logic                    cmp
);
    import exu_isa_pkg::*;

    logic [`EXU_XLEN:0]     diff;           // Top bit is the borrow
    logic                   eq;
    logic                   lt_u;
    logic                   lt_s;
    logic [4:0]             shamt;

    // One subtractor serves SUB and every compare
    assign diff  = {1'b0, op1} - {1'b0, op2};
    assign eq    = (op1 == op2);
    assign lt_u  = diff[`EXU_XLEN];
    assign lt_s  = (op1[`EXU_XLEN-1] != op2[`EXU_XLEN-1]) ? op1[`EXU_XLEN-1]
                                                          : diff[`EXU_XLEN-1];
    assign shamt = op2[4:0];

    always_comb begin
        case (ialu_cmd)
            IALU_CMD_EQ  : cmp = eq;
            IALU_CMD_NE  : cmp = ~eq;
            IALU_CMD_LT  : cmp = lt_s;
            IALU_CMD_GE  : cmp = ~lt_s;
            IALU_CMD_LTU : cmp = lt_u;
            IALU_CMD_GEU : cmp = ~lt_u;
            default      : cmp = 1'b0;              // Not a branch
        endcase
    end

    always_comb begin
        case (ialu_cmd)
            IALU_CMD_ADD  : res = op1 + op2;
            IALU_CMD_SUB  : res = diff[`EXU_XLEN-1:0];
            IALU_CMD_AND  : res = op1 & op2;
            IALU_CMD_OR   : res = op1 | op2;
            IALU_CMD_XOR  : res = op1 ^ op2;
            IALU_CMD_SLL  : res = op1 << shamt;
            IALU_CMD_SRL  : res = op1 >> shamt;
            IALU_CMD_SRA  : res = $unsigned($signed(op1) >>> shamt);
            IALU_CMD_SLT  : res = `EXU_XLEN'(lt_s);
            IALU_CMD_SLTU : res = `EXU_XLEN'(lt_u);
            IALU_CMD_EQ,
            IALU_CMD_NE,
            IALU_CMD_LT,
            IALU_CMD_GE,
            IALU_CMD_LTU,
            IALU_CMD_GEU  : res = `EXU_XLEN'(cmp);
            default       : res = '0;
        endcase
    end

    assign sum2_res = sum2_op1 + sum2_op2;      // Target adder

endmodule

// ==== exu_execute.sv ====
// --------------------------------------------------------------------
// Execute stage, combinational. Register data must return in the same
// cycle as rs1_addr and rs2_addr. Every queued instruction retires.
// --------------------------------------------------------------------

`include "exu_defines.svh"

module exu_execute (
    input  logic                    q_vd,
    input  exu_pipe_pkg::exu_cmd_s  q_cmd,
    input  logic [`EXU_XLEN-1:0]    rs1_data,
    input  logic [`EXU_XLEN-1:0]    rs2_data,
    input  logic [`EXU_XLEN-1:0]    curr_pc,
    output logic [`EXU_REG_AW-1:0]  rs1_addr,
    output logic [`EXU_REG_AW-1:0]  rs2_addr,
    output logic [`EXU_REG_AW-1:0]  rd_addr,
    output logic                    rd_w_req,
    output logic [`EXU_XLEN-1:0]    rd_data,
    exu_stage_if.execute            st
);
    import exu_isa_pkg::*;

    logic [`EXU_XLEN-1:0]   ialu_op1;
    logic [`EXU_XLEN-1:0]   ialu_op2;
    logic [`EXU_XLEN-1:0]   sum2_op1;
    logic [`EXU_XLEN-1:0]   ialu_res;
    logic [`EXU_XLEN-1:0]   sum2_res;
    logic                   ialu_cmp;
    logic [`EXU_XLEN-1:0]   inc_pc;
    logic [`EXU_XLEN-1:0]   jb_target;
    logic                   jb_req;
    logic                   jb_misalign;
    logic                   exc;

    // --------------------------------------------------------------------
    // Operands
    // --------------------------------------------------------------------

    assign rs1_addr = q_cmd.rs1_addr;
    assign rs2_addr = q_cmd.rs2_addr;

    assign ialu_op1 = rs1_data;
    assign ialu_op2 = (q_cmd.ialu_op == IALU_OP_REG_REG) ? rs2_data : q_cmd.imm;
    assign sum2_op1 = (q_cmd.sum2_op == SUM2_OP_REG_IMM) ? rs1_data : curr_pc;

    exu_ialu u_ialu (
        .ialu_cmd   (q_cmd.ialu_cmd),
        .op1        (ialu_op1),
        .op2        (ialu_op2),
        .sum2_op1   (sum2_op1),
        .sum2_op2   (q_cmd.imm),
        .res        (ialu_res),
        .sum2_res   (sum2_res),
        .cmp        (ialu_cmp)
    );

    // --------------------------------------------------------------------
    // Redirect and traps
    // --------------------------------------------------------------------

    assign inc_pc      = curr_pc + `EXU_XLEN'd4;    // No compressed instructions
    assign jb_target   = sum2_res & `EXU_JUMP_MASK;
    assign jb_req      = q_vd & (q_cmd.jump_req | (q_cmd.branch_req & ialu_cmp));
    assign jb_misalign = jb_req & jb_target[1];
    assign exc         = q_vd & (q_cmd.exc_req | jb_misalign);

    assign st.instret   = q_vd;                     // Never stalls
    assign st.jb_taken  = jb_req;
    assign st.jb_target = jb_target;
    assign st.exc       = exc;
    // Decoder exception wins over a misaligned target
    assign st.exc_code  = q_cmd.exc_req ? q_cmd.exc_code : EXC_CODE_INSTR_MISALIGN;
    assign st.trap_val  = q_cmd.exc_req ? q_cmd.imm : jb_target;

    // --------------------------------------------------------------------
    // Write-back
    // --------------------------------------------------------------------

    assign rd_addr  = q_cmd.rd_addr;
    assign rd_w_req = q_vd & (q_cmd.rd_wb_sel != RD_WB_NONE) & ~exc;

    always_comb begin
        case (q_cmd.rd_wb_sel)
            RD_WB_SUM2   : rd_data = sum2_res;     // AUIPC
            RD_WB_IMM    : rd_data = q_cmd.imm;    // LUI
            RD_WB_INC_PC : rd_data = inc_pc;       // Link address
            default      : rd_data = ialu_res;
        endcase
    end

    // Decoder must not flag both kinds of control transfer
    a_jb_exclusive : assert final (
        q_vd !== 1'b1 || !(q_cmd.jump_req && q_cmd.branch_req)
    ) else $error("exu_execute: jump_req and branch_req both set");

endmodule

// ==== exu_commit.sv ====
// --------------------------------------------------------------------
// PC register and new-PC selection. init_pc pulses once, in the third
// cycle after reset release. Traps always go to the fixed trap vector.
// --------------------------------------------------------------------

`include "exu_defines.svh"

module exu_commit (
    input  logic                    clk,
    input  logic                    rst_n,
    exu_stage_if.commit             st,
    output logic [`EXU_XLEN-1:0]    curr_pc,
    output logic                    new_pc_req,
    output logic [`EXU_XLEN-1:0]    new_pc,
    output logic                    init_pc,
    output logic                    take_exc
);
    import exu_pipe_pkg::*;

    pc_init_e   init_state;
    pc_init_e   init_next;

    // --------------------------------------------------------------------
    // Reset-exit sequencer
    // --------------------------------------------------------------------

    always_comb begin
        case (init_state)
            INIT_WAIT1 : init_next = INIT_WAIT2;
            INIT_WAIT2 : init_next = INIT_LOAD;
            INIT_LOAD  : init_next = INIT_DONE;
            default    : init_next = INIT_DONE;     // Stays here until reset
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_state <= INIT_WAIT1;
        end else begin
            init_state <= init_next;
        end
    end

    assign init_pc = (init_state == INIT_LOAD);

    // --------------------------------------------------------------------
    // New PC
    // --------------------------------------------------------------------

    assign take_exc   = st.exc;
    assign new_pc_req = init_pc | st.exc | st.jb_taken;

    always_comb begin
        if (init_pc) begin
            new_pc = `EXU_RST_VECTOR;
        end else if (st.exc) begin
            new_pc = `EXU_TRAP_VECTOR;
        end else begin
            new_pc = st.jb_target;
        end
    end

    // Reset exit reloads the vector even with nothing retiring
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc <= `EXU_RST_VECTOR;
        end else if (init_pc | st.instret) begin
            curr_pc <= new_pc_req ? new_pc : curr_pc + `EXU_XLEN'd4;
        end
    end

    // --------------------------------------------------------------------
    // Checks
    // --------------------------------------------------------------------

    // A misaligned target must turn into a trap before it reaches the PC
    a_new_pc_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        new_pc_req |-> (new_pc[1:0] == 2'b00)
    ) else $error("exu_commit: redirect to an unaligned PC");

endmodule

// ==== exu_top.sv ====
// --------------------------------------------------------------------
// Execute stage top level. No ready signal: a command with cmd_req
// high is always taken, unless new_pc_req is high in that cycle.
// --------------------------------------------------------------------

`include "exu_defines.svh"

module exu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_req,
    input  exu_pipe_pkg::exu_cmd_s  cmd,
    output logic [`EXU_REG_AW-1:0]  rs1_addr,
    output logic [`EXU_REG_AW-1:0]  rs2_addr,
    input  logic [`EXU_XLEN-1:0]    rs1_data,
    input  logic [`EXU_XLEN-1:0]    rs2_data,
    output logic                    rd_w_req,
    output logic [`EXU_REG_AW-1:0]  rd_addr,
    output logic [`EXU_XLEN-1:0]    rd_data,
    output logic                    instret,
    output logic                    take_exc,
    output exu_isa_pkg::exc_code_e  exc_code,
    output logic [`EXU_XLEN-1:0]    trap_val,
    output logic [`EXU_XLEN-1:0]    curr_pc,
    output logic                    new_pc_req,
    output logic [`EXU_XLEN-1:0]    new_pc,
    output logic                    init_pc
);
    import exu_pipe_pkg::*;

    logic       q_vd;
    exu_cmd_s   q_cmd;

    exu_stage_if st_if ();

    exu_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .new_pc_req (new_pc_req),
        .q_vd       (q_vd),
        .q_cmd      (q_cmd)
    );

    exu_execute u_execute (
        .q_vd       (q_vd),
        .q_cmd      (q_cmd),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .curr_pc    (curr_pc),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rd_addr    (rd_addr),
        .rd_w_req   (rd_w_req),
        .rd_data    (rd_data),
        .st         (st_if.execute)
    );

    exu_commit u_commit (
        .clk        (clk),
        .rst_n      (rst_n),
        .st         (st_if.commit),
        .curr_pc    (curr_pc),
        .new_pc_req (new_pc_req),
        .new_pc     (new_pc),
        .init_pc    (init_pc),
        .take_exc   (take_exc)
    );

    assign instret  = st_if.instret;
    assign exc_code = st_if.exc_code;
    assign trap_val = st_if.trap_val;

endmodule

// ==== tb_exu_top.sv ====
// --------------------------------------------------------------------
// Self-checking testbench for exu_top. A register file model answers
// reads combinationally; a reference model tracks queue and PC.
// --------------------------------------------------------------------

`include "exu_defines.svh"

module tb_exu_top;
    timeunit 1ns;
    timeprecision 1ps;
    import exu_isa_pkg::*;
    import exu_pipe_pkg::*;

    localparam int N_ALU   = 300;
    localparam int N_JB    = 200;
    localparam int N_EXC   = 40;
    localparam int N_SLOTS = N_ALU + N_JB + N_EXC + 1;     // Plus the reset-exit command

    typedef struct packed {
        logic                   ret;
        logic                   jb;
        logic                   exc;
        logic [3:0]             code;
        logic [`EXU_XLEN-1:0]   tval;
        logic                   wr;
        logic [`EXU_XLEN-1:0]   wdata;
        logic                   req;
        logic [`EXU_XLEN-1:0]   npc;
        logic [`EXU_XLEN-1:0]   next_pc;
    } ref_s;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   cmd_req;
    exu_cmd_s               cmd;
    logic [`EXU_REG_AW-1:0] rs1_addr, rs2_addr, rd_addr;
    logic [`EXU_XLEN-1:0]   rs1_data, rs2_data, rd_data;
    logic                   rd_w_req, instret, take_exc, new_pc_req, init_pc;
    exc_code_e              exc_code;
    logic [`EXU_XLEN-1:0]   trap_val, curr_pc, new_pc;

    logic [31:0]            seed = 32'h8d95;
    logic [`EXU_XLEN-1:0]   regs [32];              // Register file model
    logic                   m_vd;                   // Model of the queue
    exu_cmd_s               m_cmd;
    logic [`EXU_XLEN-1:0]   m_pc;
    int                     rst_cyc;
    ref_s                   ref_out;
    int                     init_cnt = 0, jb_cnt = 0, exc_cnt = 0, mis_cnt = 0, drop_cnt = 0;

    always #5 clk = ~clk;

    exu_top DUT (.*);

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // --------------------------------------------------------------------
    // Reference model
    // --------------------------------------------------------------------

    function automatic ref_s ref_model(input logic vd, input logic init, input exu_cmd_s c,
                                       input logic [31:0] a, input logic [31:0] b,
                                       input logic [31:0] pc);
        ref_s        e;
        logic [31:0] op2;
        logic [31:0] sum;
        logic [31:0] tgt;
        logic [31:0] alu;
        logic        taken;
        op2   = (c.ialu_op == IALU_OP_REG_IMM) ? c.imm : b;
        sum   = ((c.sum2_op == SUM2_OP_REG_IMM) ? a : pc) + c.imm;
        tgt   = sum & `EXU_JUMP_MASK;
        taken = 1'b0;
        case (c.ialu_cmd)
            IALU_CMD_ADD  : alu = a + op2;
            IALU_CMD_SUB  : alu = a - op2;
            IALU_CMD_AND  : alu = a & op2;
            IALU_CMD_OR   : alu = a | op2;
            IALU_CMD_XOR  : alu = a ^ op2;
            IALU_CMD_SLL  : alu = a << op2[4:0];
            IALU_CMD_SRL  : alu = a >> op2[4:0];
            IALU_CMD_SRA  : alu = $signed(a) >>> op2[4:0];
            IALU_CMD_SLT  : alu = {31'd0, $signed(a) < $signed(op2)};
            IALU_CMD_SLTU : alu = {31'd0, a < op2};
            IALU_CMD_EQ   : taken = (a == op2);
            IALU_CMD_NE   : taken = (a != op2);
            IALU_CMD_LT   : taken = ($signed(a) < $signed(op2));
            IALU_CMD_GE   : taken = ($signed(a) >= $signed(op2));
            IALU_CMD_LTU  : taken = (a < op2);
            IALU_CMD_GEU  : taken = (a >= op2);
            default       : alu = '0;
        endcase
        if (c.ialu_cmd >= IALU_CMD_EQ) alu = {31'd0, taken};     // Compare result as value
        e.ret  = vd;
        e.jb   = vd && (c.jump_req || (c.branch_req && taken));
        e.exc  = vd && (c.exc_req || (e.jb && tgt[1]));
        e.code = c.exc_req ? c.exc_code : EXC_CODE_INSTR_MISALIGN;
        e.tval = c.exc_req ? c.imm : tgt;
        e.wr   = vd && (c.rd_wb_sel != RD_WB_NONE) && !e.exc;
        case (c.rd_wb_sel)
            RD_WB_SUM2   : e.wdata = sum;
            RD_WB_IMM    : e.wdata = c.imm;
            RD_WB_INC_PC : e.wdata = pc + 32'd4;
            default      : e.wdata = alu;
        endcase
        e.req     = init || e.exc || e.jb;
        e.npc     = init ? `EXU_RST_VECTOR : (e.exc ? `EXU_TRAP_VECTOR : tgt);
        e.next_pc = (init || vd) ? (e.req ? e.npc : pc + 32'd4) : pc;
        return e;
    endfunction

    always_comb begin
        ref_out = ref_model(m_vd, rst_n && (rst_cyc == 2), m_cmd,
                            regs[m_cmd.rs1_addr], regs[m_cmd.rs2_addr], m_pc);
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_vd    <= 1'b0;
            m_cmd   <= '0;
            m_pc    <= `EXU_RST_VECTOR;
            rst_cyc <= 0;
        end else begin
            m_vd <= cmd_req && !ref_out.req;                // Dropped on any new PC
            if (cmd_req && !ref_out.req) m_cmd <= cmd;
            if (cmd_req && ref_out.req) drop_cnt <= drop_cnt + 1;
            m_pc <= ref_out.next_pc;
            if (rst_cyc < 3) rst_cyc <= rst_cyc + 1;
            if (rd_w_req) regs[rd_addr] <= rd_data;
        end
    end

    // --------------------------------------------------------------------
    // Checker
    // --------------------------------------------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            abort_run($sformatf("** Error at %0t ns: %s expected 0x%08h, actual 0x%08h",
                                $time, name, exp_v, act_v));
        end
    endtask

    always @(negedge clk) begin
        check_val("instret", ref_out.ret, instret);
        check_val("init_pc", rst_n && (rst_cyc == 2), init_pc);
        check_val("new_pc_req", ref_out.req, new_pc_req);
        check_val("take_exc", ref_out.exc, take_exc);
        check_val("rd_w_req", ref_out.wr, rd_w_req);
        check_val("curr_pc", m_pc, curr_pc);
        if (ref_out.ret) begin
            check_val("rs1_addr", m_cmd.rs1_addr, rs1_addr);
            check_val("rs2_addr", m_cmd.rs2_addr, rs2_addr);
        end
        if (ref_out.req) check_val("new_pc", ref_out.npc, new_pc);
        if (ref_out.wr) begin
            check_val("rd_addr", m_cmd.rd_addr, rd_addr);
            check_val("rd_data", ref_out.wdata, rd_data);
        end
        if (ref_out.exc) begin
            check_val("exc_code", ref_out.code, exc_code);
            check_val("trap_val", ref_out.tval, trap_val);
        end
        init_cnt = init_cnt + init_pc;
        jb_cnt   = jb_cnt + (ref_out.jb && !ref_out.exc);
        exc_cnt  = exc_cnt + ref_out.exc;
        mis_cnt  = mis_cnt + (ref_out.exc && !m_cmd.exc_req);
    end

    initial begin
        #((N_SLOTS + 50) * 10);
        abort_run("Timeout: the test sequence did not complete in time");
    end

    // --------------------------------------------------------------------
    // Stimulus
    // --------------------------------------------------------------------

    task automatic make_cmd(input int kind, output exu_cmd_s c);
        logic [31:0] r;
        logic [31:0] s;
        r = $random(seed);
        s = $random(seed);
        c = '0;
        c.rs1_addr = r[4:0];
        c.rs2_addr = r[9:5];
        c.rd_addr  = r[14:10];
        c.imm      = s;
        case (kind)
            0 : begin                                       // Plain ALU op
                c.ialu_cmd  = ialu_cmd_e'(1 + (r[23:16] % 10));
                c.ialu_op   = ialu_op_e'(r[24]);
                c.rd_wb_sel = RD_WB_IALU;
            end
            1 : begin                                       // AUIPC
                c.imm       = {s[31:12], 12'd0};
                c.rd_wb_sel = RD_WB_SUM2;
            end
            2 : begin                                       // LUI
                c.imm       = {s[31:12], 12'd0};
                c.rd_wb_sel = RD_WB_IMM;
            end
            3 : begin
                c.sum2_op   = SUM2_OP_REG_IMM;
                c.rd_wb_sel = RD_WB_SUM2;
            end
            4, 5 : begin                                    // JAL, JALR
                c.imm       = {{19{s[12]}}, s[12:2], s[31] & s[30], s[0]};
                c.jump_req  = 1'b1;
                c.sum2_op   = (kind == 5) ? SUM2_OP_REG_IMM : SUM2_OP_PC_IMM;
                c.rd_wb_sel = RD_WB_INC_PC;
            end
            default : begin                                 // Branch, maybe flagged
                c.imm        = {{19{s[12]}}, s[12:2], s[31] & s[30], s[0]};
                c.ialu_cmd   = ialu_cmd_e'(11 + (r[23:16] % 6));
                c.branch_req = 1'b1;
                if (r[25]) c.rs2_addr = c.rs1_addr;         // Forces EQ and GE taken
                if (kind == 7) begin
                    c.exc_req   = 1'b1;
                    c.imm[1]    = 1'b1;                     // Misaligned as well
                    c.rd_wb_sel = RD_WB_IALU;
                    case (r[27:26])
                        2'd0    : c.exc_code = EXC_CODE_INSTR_MISALIGN;
                        2'd1    : c.exc_code = EXC_CODE_ILLEGAL_INSTR;
                        2'd2    : c.exc_code = EXC_CODE_BREAKPOINT;
                        default : c.exc_code = EXC_CODE_ECALL_M;
                    endcase
                end
            end
        endcase
    endtask

    task automatic drive_slot(input int kind);
        exu_cmd_s    c;
        logic [31:0] r;
        make_cmd(kind, c);
        r = $random(seed);
        @(posedge clk);
        #1;
        cmd_req = (r[2:0] != 3'd0);                         // Idle about one slot in eight
        cmd     = c;
    endtask

    initial begin
        exu_cmd_s c;
        logic [31:0] r;
        rst_n   = 1'b0;
        cmd_req = 1'b0;
        cmd     = '0;
        for (int i = 0; i < 32; i++) regs[i] = $random(seed);
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        make_cmd(0, c);
        repeat (2) @(posedge clk);
        #1;
        cmd_req = 1'b1;                                     // Lands in the init_pc cycle
        cmd     = c;
        for (int i = 0; i < N_ALU; i++) begin
            r = $random(seed);
            drive_slot((r[2:0] < 5) ? 0 : r[2:0] - 4);
        end
        for (int i = 0; i < N_JB; i++) begin
            r = $random(seed);
            drive_slot((r[1:0] == 0) ? 0 : r[1:0] + 3);
        end
        for (int i = 0; i < N_EXC; i++) begin
            r = $random(seed);
            drive_slot(r[0] ? 7 : 0);
        end
        @(posedge clk);
        #1 cmd_req = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (init_cnt == 1 && drop_cnt > 0 && jb_cnt > 0 && mis_cnt > 0 && exc_cnt > mis_cnt) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            abort_run($sformatf("Check failed: init pulses %0d, drops %0d, jumps %0d, traps %0d",
                                init_cnt, drop_cnt, jb_cnt, exc_cnt));
        end
    end

endmodule

// ==== rv_exu.f ====
+incdir+.
exu_isa_pkg.sv
exu_pipe_pkg.sv
exu_stage_if.sv
exu_queue.sv
exu_ialu.sv
exu_execute.sv
exu_commit.sv
exu_top.sv
tb_exu_top.sv
